// File: fpint_pkg.sv
//******************************
// FP/INT lane package
// Single-precision format types, operation codes
// and float classify/unpack helpers
//******************************

package fpint_pkg;

	typedef logic [31:0] word;
	typedef logic [7:0]  float_exp;
	typedef logic [22:0] float_mant;

	// Hidden one, stored mantissa, then guard, round and sticky places
	typedef logic [26:0] mant_ext;

	typedef logic [1:0]  fpint_op;

	localparam fpint_op OP_FADD = 2'd0;
	localparam fpint_op OP_FSUB = 2'd1;
	localparam fpint_op OP_FMUL = 2'd2;
	localparam fpint_op OP_ITOF = 2'd3;

	localparam float_exp EXP_BIAS = 8'd127;
	localparam float_exp EXP_MAX  = 8'd255;

	// All-ones exponent with mantissa 1
	localparam word CANON_NAN = {1'b0, EXP_MAX, 23'd1};

	// NaN or infinity
	function automatic logic is_special(word w);
		return &w[30:23];
	endfunction

	function automatic logic is_zero_or_denormal(word w);
		return ~|w[30:23];
	endfunction

	// Denormals read as zero
	function automatic logic [23:0] significand(word w);
		if (is_zero_or_denormal(w))
			return '0;
		return {1'b1, w[22:0]};
	endfunction

	function automatic mant_ext unpack_mant(word w);
		return {significand(w), 3'b000};
	endfunction

endpackage

// File: fpint_ctrl.sv
//******************************
// FP/INT lane control
// Decodes the issued op and delays per-stage
// control levels alongside the datapath
//******************************

`timescale 1ns/1ns

module fpint_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue,
	input  fpint_pkg::fpint_op op,
	output logic               is_mul_1,
	output logic               is_sub_1,
	output logic               is_int_1,
	output logic               do_round_6,
	output logic               valid_6
);

	import fpint_pkg::*;

	logic dec_mul, dec_sub, dec_int;

	// Bit k is high while a valid op sits in the stage k registers
	logic [6:1] valid_sr;

	always_comb begin
		dec_mul = 1'b0;
		dec_sub = 1'b0;
		dec_int = 1'b0;
		case (op)
			OP_FADD: ;
			OP_FSUB: dec_sub = 1'b1;
			OP_FMUL: dec_mul = 1'b1;
			OP_ITOF: dec_int = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			is_mul_1 <= 1'b0;
			is_sub_1 <= 1'b0;
			is_int_1 <= 1'b0;
			valid_sr <= '0;
		end else begin
			is_mul_1 <= issue & dec_mul;
			is_sub_1 <= issue & dec_sub;
			is_int_1 <= issue & dec_int;
			valid_sr <= {valid_sr[5:1], issue};
		end
	end

	// Op held in stage 5 is being rounded by stage 6 logic
	assign do_round_6 = valid_sr[5];
	assign valid_6    = valid_sr[6];

endmodule

// File: fpint_mul_align.sv
//******************************
// FP/INT lane front half
// Unpacks, multiplies, orders operands by
// magnitude and aligns the smaller mantissa
//******************************

`timescale 1ns/1ns

module fpint_mul_align (
	input  logic                clk,
	input  fpint_pkg::word      a,
	input  fpint_pkg::word      b,
	input  logic                is_mul_1,
	input  logic                is_sub_1,
	input  logic                is_int_1,
	output logic                max_sign,
	output fpint_pkg::float_exp max_exp,
	output fpint_pkg::mant_ext  max_mant,
	output fpint_pkg::mant_ext  min_mant,
	output logic                eff_sub,
	output logic                sticky,
	output logic                force_nan,
	output logic                force_zero,
	output logic                pass_int
);

	import fpint_pkg::*;

	word a_1, b_1;
	logic [47:0] prod_1;
	logic [9:0] exp_sum_1;

	logic sa_2, sb_2, nan_2, zero_2, int_2;
	float_exp ea_2, eb_2;
	mant_ext ma_2, mb_2;

	logic [9:0] mul_exp;
	mant_ext prod_mant;
	word int_mag;

	logic swap;
	float_exp exp_diff;
	logic [4:0] shift;
	mant_ext min_pre;

	// Stage 1: raw operands, 24x24 product and biased exponent sum
	always_ff @(posedge clk) begin
		a_1 <= a;
		b_1 <= b;
		prod_1 <= {24'b0, significand(a)} * {24'b0, significand(b)};
		exp_sum_1 <= {2'b0, a[30:23]} + {2'b0, b[30:23]} - {2'b0, EXP_BIAS};
	end

	// Product of two values in [1,4) needs at most one place of shift
	always_comb begin
		if (prod_1[47]) begin
			prod_mant = {prod_1[47:24], prod_1[23], prod_1[22], |prod_1[21:0]};
			mul_exp = exp_sum_1 + 10'd1;
		end else begin
			prod_mant = {prod_1[46:23], prod_1[22], prod_1[21], |prod_1[20:0]};
			mul_exp = exp_sum_1;
		end
		int_mag = a_1[31] ? -a_1 : a_1;
	end

	// Stage 2: subtract flip, product replaces a, integer split across a and b
	always_ff @(posedge clk) begin
		int_2 <= is_int_1;
		zero_2 <= 1'b0;
		nan_2 <= is_special(a_1) | is_special(b_1);
		sa_2 <= a_1[31];
		sb_2 <= b_1[31] ^ is_sub_1;
		ea_2 <= a_1[30:23];
		eb_2 <= b_1[30:23];
		ma_2 <= unpack_mant(a_1);
		mb_2 <= unpack_mant(b_1);

		if (is_mul_1) begin
			sa_2 <= a_1[31] ^ b_1[31];
			sb_2 <= a_1[31] ^ b_1[31];
			ea_2 <= mul_exp[7:0];
			ma_2 <= prod_mant;
			eb_2 <= '0;
			mb_2 <= '0;
			nan_2 <= is_special(a_1) | is_special(b_1)
				| (~mul_exp[9] & (mul_exp[8:0] >= {1'b0, EXP_MAX}));
			zero_2 <= is_zero_or_denormal(a_1) | is_zero_or_denormal(b_1)
				| mul_exp[9] | (mul_exp == 10'd0);
		end else if (is_int_1) begin
			// Reference exponent 30 puts magnitude bit 30 on the hidden one
			nan_2 <= 1'b0;
			ea_2 <= EXP_BIAS + 8'd30;
			ma_2 <= int_mag[31:5];
			eb_2 <= '0;
			mb_2 <= {22'b0, int_mag[4:0]};
		end
	end

	// Sign-magnitude compare of exponent and mantissa
	assign swap = ~int_2 & ({eb_2, mb_2} > {ea_2, ma_2});

	always_comb begin
		if (swap) begin
			exp_diff = eb_2 - ea_2;
			min_pre = ma_2;
		end else begin
			exp_diff = ea_2 - eb_2;
			min_pre = mb_2;
		end
		if (int_2)
			shift = '0;
		else if (exp_diff > 8'd27)
			shift = 5'd27;
		else
			shift = exp_diff[4:0];
	end

	// Stage 3: larger magnitude first, smaller one aligned
	always_ff @(posedge clk) begin
		max_sign <= swap ? sb_2 : sa_2;
		max_exp <= swap ? eb_2 : ea_2;
		max_mant <= swap ? mb_2 : ma_2;
		min_mant <= min_pre >> shift;
		sticky <= |(min_pre & ~({$bits(mant_ext){1'b1}} << shift));
		eff_sub <= sa_2 ^ sb_2;
		force_nan <= nan_2;
		force_zero <= zero_2;
		pass_int <= int_2;
	end

endmodule

// File: fpint_add_norm.sv
//******************************
// FP/INT lane back half
// Mantissa add/subtract, leading zero count,
// normalization and round to nearest even
//******************************

`timescale 1ns/1ns

module fpint_add_norm (
	input  logic                 clk,
	input  logic                 max_sign,
	input  fpint_pkg::float_exp  max_exp,
	input  fpint_pkg::mant_ext   max_mant,
	input  fpint_pkg::mant_ext   min_mant,
	input  logic                 eff_sub,
	input  logic                 sticky,
	input  logic                 force_nan,
	input  logic                 force_zero,
	input  logic                 pass_int,
	input  logic                 do_round_6,
	output logic                 res_sign,
	output fpint_pkg::float_exp  res_exp,
	output fpint_pkg::float_mant res_mant,
	output logic                 res_nan,
	output logic                 res_zero
);

	import fpint_pkg::*;

	// Bit 31 is the carry place, bit 30 the hidden one at max_exp
	word wide_4;
	logic sign_4, nan_4, zero_4;
	float_exp exp_4;

	logic [27:0] sum;
	mant_ext min_sticky;

	logic [5:0] lz;
	word norm;
	logic [9:0] norm_exp;
	logic zero_norm;

	logic sign_5, nan_5, zero_5, guard_5, sticky_5;
	float_exp exp_5;
	float_mant mant_5;

	logic round_up;
	logic [23:0] mant_inc;
	logic [8:0] exp_inc;

	// Shifted-out bits act as one extra low bit of the smaller operand
	assign min_sticky = min_mant | {26'b0, sticky};

	always_comb begin
		if (eff_sub)
			sum = {1'b0, max_mant} - {1'b0, min_sticky};
		else
			sum = {1'b0, max_mant} + {1'b0, min_sticky};
	end

	// Stage 4
	always_ff @(posedge clk) begin
		exp_4 <= max_exp;
		sign_4 <= max_sign;
		nan_4 <= force_nan;
		zero_4 <= force_zero;
		if (pass_int) begin
			wide_4 <= {max_mant, min_mant[4:0]};
		end else begin
			wide_4 <= {sum, 4'b0};
			// Exact cancellation gives +0
			if (eff_sub & (sum == '0))
				sign_4 <= 1'b0;
		end
	end

	always_comb begin
		lz = 6'd32;
		for (int i = 0; i < 32; i++)
			if (wide_4[i])
				lz = 6'(31 - i);
		norm = wide_4 << lz;
		norm_exp = {2'b0, exp_4} + 10'd1 - {4'b0, lz};
	end

	// Cancelled or underflowed results carry no exponent into rounding
	assign zero_norm = zero_4 | (wide_4 == '0) | norm_exp[9] | (norm_exp == 10'd0);

	// Stage 5: leading one to bit 31, guard below the stored mantissa
	always_ff @(posedge clk) begin
		sign_5 <= sign_4;
		exp_5 <= zero_norm ? '0 : norm_exp[7:0];
		mant_5 <= norm[30:8];
		guard_5 <= norm[7];
		sticky_5 <= |norm[6:0];
		nan_5 <= nan_4 | (~zero_norm & (norm_exp[8:0] >= {1'b0, EXP_MAX}));
		zero_5 <= zero_norm;
	end

	// Ties go up only when the mantissa is odd
	assign round_up = do_round_6 & guard_5 & (sticky_5 | mant_5[0]);
	assign mant_inc = {1'b0, mant_5} + {23'b0, round_up};
	assign exp_inc = {1'b0, exp_5} + {8'b0, mant_inc[23]};

	// Stage 6: a mantissa carry leaves zero mantissa and bumps the exponent
	always_ff @(posedge clk) begin
		res_sign <= sign_5;
		res_mant <= mant_inc[22:0];
		res_exp <= exp_inc[7:0];
		res_nan <= nan_5 | exp_inc[8] | (exp_inc[7:0] == EXP_MAX);
		res_zero <= zero_5;
	end

endmodule

// File: fpint_encode.sv
//******************************
// FP/INT lane output encoder
// Forces canonical NaN or zero and
// registers the result with its valid
//******************************

`timescale 1ns/1ns

module fpint_encode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 res_sign,
	input  fpint_pkg::float_exp  res_exp,
	input  fpint_pkg::float_mant res_mant,
	input  logic                 force_nan,
	input  logic                 force_zero,
	input  logic                 valid_6,
	output fpint_pkg::word       q,
	output logic                 q_valid
);

	import fpint_pkg::*;

	always_ff @(posedge clk) begin
		if (reset)
			q_valid <= 1'b0;
		else
			q_valid <= valid_6;
	end

	// NaN takes priority over zero
	always_ff @(posedge clk) begin
		if (force_nan | is_special({res_sign, res_exp, res_mant}))
			q <= CANON_NAN;
		else if (force_zero)
			q <= {res_sign, 31'b0};
		else
			q <= {res_sign, res_exp, res_mant};
	end

endmodule

// File: fpint_unit.sv
//******************************
// FP/INT arithmetic lane top
// Seven-cycle pipeline for fadd, fsub, fmul, itof
//******************************

`timescale 1ns/1ns

module fpint_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue,
	input  fpint_pkg::fpint_op op,
	input  fpint_pkg::word     a,
	input  fpint_pkg::word     b,
	output fpint_pkg::word     q,
	output logic               q_valid
);

	import fpint_pkg::*;

	logic is_mul_1, is_sub_1, is_int_1, do_round_6, valid_6;

	logic max_sign, eff_sub, sticky, force_nan, force_zero, pass_int;
	float_exp max_exp;
	mant_ext max_mant, min_mant;

	logic res_sign, res_nan, res_zero;
	float_exp res_exp;
	float_mant res_mant;

	fpint_ctrl i_ctrl (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.op(op),
		.is_mul_1(is_mul_1),
		.is_sub_1(is_sub_1),
		.is_int_1(is_int_1),
		.do_round_6(do_round_6),
		.valid_6(valid_6)
	);

	fpint_mul_align i_front (
		.clk(clk),
		.a(a),
		.b(b),
		.is_mul_1(is_mul_1),
		.is_sub_1(is_sub_1),
		.is_int_1(is_int_1),
		.max_sign(max_sign),
		.max_exp(max_exp),
		.max_mant(max_mant),
		.min_mant(min_mant),
		.eff_sub(eff_sub),
		.sticky(sticky),
		.force_nan(force_nan),
		.force_zero(force_zero),
		.pass_int(pass_int)
	);

	fpint_add_norm i_back (
		.clk(clk),
		.max_sign(max_sign),
		.max_exp(max_exp),
		.max_mant(max_mant),
		.min_mant(min_mant),
		.eff_sub(eff_sub),
		.sticky(sticky),
		.force_nan(force_nan),
		.force_zero(force_zero),
		.pass_int(pass_int),
		.do_round_6(do_round_6),
		.res_sign(res_sign),
		.res_exp(res_exp),
		.res_mant(res_mant),
		.res_nan(res_nan),
		.res_zero(res_zero)
	);

	fpint_encode i_encode (
		.clk(clk),
		.reset(reset),
		.res_sign(res_sign),
		.res_exp(res_exp),
		.res_mant(res_mant),
		.force_nan(res_nan),
		.force_zero(res_zero),
		.valid_6(valid_6),
		.q(q),
		.q_valid(q_valid)
	);

endmodule

// File: tb_fpint_assert.sv
//******************************
// FP/INT lane assertions
// Valid timing and reset rules,
// bound into the lane top
//******************************

`timescale 1ns/1ns

module tb_fpint_assert (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic q_valid
);

	localparam int LATENCY = 7;

	// Each result appears a fixed number of cycles after its issue
	valid_latency: assert property (@(posedge clk) disable iff (reset)
		q_valid == $past(issue, LATENCY))
		else $error("q_valid does not follow issue by %0d cycles", LATENCY);

	reset_clears_valid: assert property (@(posedge clk) $past(reset) |-> !q_valid)
		else $error("q_valid high right after a reset cycle");

endmodule

bind fpint_unit tb_fpint_assert i_assert (
	.clk(clk),
	.reset(reset),
	.issue(issue),
	.q_valid(q_valid)
);

// File: tb_fpint_check.sv
//******************************
// FP/INT lane result checker
// Queues expected results at issue, compares
// them with q when q_valid is high
//******************************

`timescale 1ns/1ns

module tb_fpint_check (
	input  logic           clk,
	input  logic           reset,
	input  logic           issue,
	input  logic [127:0]   test_name,
	input  fpint_pkg::word expected,
	input  fpint_pkg::word q,
	input  logic           q_valid,
	input  logic           done,
	output int             mismatches,
	output int             other_errors
);

	import fpint_pkg::*;

	localparam int LATENCY = 7;

	logic [127:0] name_q[$];
	word exp_q[$];
	int cycle_q[$];
	int cycle;
	logic leftovers_seen;

	initial begin
		mismatches = 0;
		other_errors = 0;
		cycle = 0;
		leftovers_seen = 1'b0;
	end

	// Flop outputs are read here before they update on this edge
	always @(posedge clk) begin : compare
		logic [127:0] name_head;
		word exp_head;
		int issued_at;

		if (reset && cycle > 0 && q_valid !== 1'b0) begin
			other_errors++;
			$display("ERROR: q_valid not low during reset at cycle %0d", cycle);
		end

		if (!reset && issue) begin
			name_q.push_back(test_name);
			exp_q.push_back(expected);
			cycle_q.push_back(cycle);
		end

		if (!reset && q_valid === 1'b1) begin
			if (name_q.size() == 0) begin
				other_errors++;
				$display("ERROR: q_valid high at cycle %0d with nothing outstanding", cycle);
			end else begin
				name_head = name_q.pop_front();
				exp_head = exp_q.pop_front();
				issued_at = cycle_q.pop_front();
				if (cycle - issued_at != LATENCY) begin
					other_errors++;
					$display("ERROR: %0s came %0d cycles after issue instead of %0d",
						name_head, cycle - issued_at, LATENCY);
				end
				if (q !== exp_head) begin
					mismatches++;
					$display("MISMATCH %0s: expected %08h, actual %08h",
						name_head, exp_head, q);
				end
			end
		end

		if (done && !leftovers_seen) begin
			leftovers_seen = 1'b1;
			if (name_q.size() > 0) begin
				other_errors += name_q.size();
				$display("ERROR: %0d issued operations never produced a result",
					name_q.size());
			end
		end

		cycle++;
	end

endmodule

// File: tb_fpint.sv
//******************************
// FP/INT lane testbench
// Reads cases from file, drives the lane and
// reports the checker's error counts
//******************************

`timescale 1ns/1ns

module tb_fpint;

	import fpint_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int LATENCY = 7;

	logic clk;
	logic reset;
	logic issue;
	fpint_op op;
	word a;
	word b;
	word q;
	logic q_valid;

	logic [127:0] test_name;
	word expected;
	logic done;
	int mismatches;
	int other_errors;

	logic [127:0] name_list[$];
	fpint_op op_list[$];
	word a_list[$];
	word b_list[$];
	word exp_list[$];

	fpint_unit i_dut (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.op(op),
		.a(a),
		.b(b),
		.q(q),
		.q_valid(q_valid)
	);

	tb_fpint_check i_check (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.test_name(test_name),
		.expected(expected),
		.q(q),
		.q_valid(q_valid),
		.done(done),
		.mismatches(mismatches),
		.other_errors(other_errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Lines starting with # hold column notes
	task automatic read_cases(output int count);
		int fd;
		string line;
		logic [127:0] nm;
		fpint_op opv;
		word av;
		word bv;
		word ev;

		count = 0;
		fd = $fopen("fpint_cases.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%s %h %h %h %h", nm, opv, av, bv, ev) == 5) begin
						name_list.push_back(nm);
						op_list.push_back(opv);
						a_list.push_back(av);
						b_list.push_back(bv);
						exp_list.push_back(ev);
						count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_case(int idx);
		@(negedge clk);
		issue = 1'b1;
		op = op_list[idx];
		a = a_list[idx];
		b = b_list[idx];
		test_name = name_list[idx];
		expected = exp_list[idx];
	endtask

	task automatic drive_idle(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			issue = 1'b0;
		end
	endtask

	task automatic end_on_timeout(int cycles);
		repeat (cycles) @(posedge clk);
		$display("Timeout: run not finished after %0d cycles", cycles);
		$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin : stimulus
		int n_cases;
		int gap;

		clk = 1'b0;
		reset = 1'b1;
		issue = 1'b0;
		op = OP_FADD;
		a = '0;
		b = '0;
		test_name = '0;
		expected = '0;
		done = 1'b0;
		void'($urandom(37));
		read_cases(n_cases);

		if (n_cases == 0) begin
			$display("No test could be read from fpint_cases.txt");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			fork
				end_on_timeout(n_cases * 4 + 20);
			join_none

			// First half back to back, second half with 0 to 3 idle cycles
			for (int i = 0; i < n_cases; i++) begin
				drive_case(i);
				if (i >= n_cases / 2) begin
					gap = $urandom % 4;
					drive_idle(gap);
				end
			end
			drive_idle(LATENCY + 2);
			done = 1'b1;
			@(posedge clk);
			@(negedge clk);

			$display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
			if (mismatches == 0 && other_errors == 0) begin
				$display("ALL CHECKS PASSED");
			end else begin
				$display("CHECKS FAILED");
			end
			$finish;
		end
	end

endmodule

// File: fpint_cases.txt
# name op a b expected, all values in hex
# op codes: 0 fadd, 1 fsub, 2 fmul, 3 itof (b unused for itof)
add_simple     0 3F800000 40000000 40400000
add_tie_even   0 3F800000 33800000 3F800000
add_tie_up     0 3F800001 33800000 3F800002
sub_cancel     1 3F800001 3F800000 34000000
sub_negative   1 3FC00000 40200000 BF800000
mul_simple     2 3FC00000 40000000 40400000
mul_norm_shift 2 3FC00000 3FC00000 40100000
itof_pos       3 00000064 00000000 42C80000
itof_neg       3 FFFFFFFB 00000000 C0A00000
itof_zero      3 00000000 00000000 00000000
itof_max       3 7FFFFFFF 00000000 4F000000
itof_tie       3 01000001 00000000 4B800000
add_nan        0 7FC00000 3F800000 7F800001
mul_inf        2 7F800000 3F800000 7F800001
mul_overflow   2 71800000 71800000 7F800001
mul_denormal   2 00400000 40000000 00000000

// File: src.f
fpint_pkg.sv
fpint_ctrl.sv
fpint_mul_align.sv
fpint_add_norm.sv
fpint_encode.sv
fpint_unit.sv
tb_fpint_assert.sv
tb_fpint_check.sv
tb_fpint.sv

// File: Makefile
SIM        = verilator
TOP        = tb_fpint
FILELIST   = src.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert
RUN_ARGS   = +verilator+error+limit+100
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
